// File: hdl/riscvPkg.sv
package riscvPkg;

    typedef logic [31:0] dataWord;

    // ############################################################
    // major opcodes, bits 6:0 of the instruction.
    // ############################################################
    typedef enum logic [6:0] {
        OP_R     = 7'b0110011,
        OP_I     = 7'b0010011,
        OP_L     = 7'b0000011,
        OP_S     = 7'b0100011,
        OP_B     = 7'b1100011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111
    } opcodeT;

    // last six are branch compares, result 0 or 1.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
        ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } aluOpT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_IMM,
        WB_PCPLUS4
    } wbSelT;

    // load/store width, same code as funct3.
    typedef enum logic [2:0] {
        ACC_BYTE  = 3'b000,
        ACC_HALF  = 3'b001,
        ACC_WORD  = 3'b010,
        ACC_UBYTE = 3'b100,
        ACC_UHALF = 3'b101
    } accessT;

endpackage

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  riscvPkg::aluOpT   aluOp,
    input  riscvPkg::dataWord a,
    input  riscvPkg::dataWord b,
    output riscvPkg::dataWord result
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluOp)
            riscvPkg::ALU_ADD:  result = a + b;
            riscvPkg::ALU_SUB:  result = a - b;
            riscvPkg::ALU_SLL:  result = a << shamt;
            riscvPkg::ALU_SRL:  result = a >> shamt;
            riscvPkg::ALU_SRA:  result = $signed(a) >>> shamt;
            riscvPkg::ALU_XOR:  result = a ^ b;
            riscvPkg::ALU_OR:   result = a | b;
            riscvPkg::ALU_AND:  result = a & b;
            // compares, 0 or 1.
            riscvPkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            riscvPkg::ALU_SLTU: result = {31'd0, a < b};
            riscvPkg::ALU_EQ:   result = {31'd0, a == b};
            riscvPkg::ALU_NE:   result = {31'd0, a != b};
            riscvPkg::ALU_LT:   result = {31'd0, $signed(a) < $signed(b)};
            riscvPkg::ALU_GE:   result = {31'd0, $signed(a) >= $signed(b)};
            riscvPkg::ALU_LTU:  result = {31'd0, a < b};
            riscvPkg::ALU_GEU:  result = {31'd0, a >= b};
            default:            result = '0;
        endcase
    end

endmodule

// File: hdl/immExtend.sv
`timescale 1ns/1ps

module immExtend (
    input  riscvPkg::dataWord instrCode,
    output riscvPkg::dataWord immExt
);
    logic [2:0]        funct3;
    riscvPkg::dataWord immI, immS, immB, immU, immJ;

    assign funct3 = instrCode[14:12];

    assign immI = {{20{instrCode[31]}}, instrCode[31:20]};
    assign immS = {{20{instrCode[31]}}, instrCode[31:25], instrCode[11:7]};
    assign immB = {{20{instrCode[31]}}, instrCode[7], instrCode[30:25],
                   instrCode[11:8], 1'b0};
    assign immU = {instrCode[31:12], 12'd0};
    assign immJ = {{12{instrCode[31]}}, instrCode[19:12], instrCode[20],
                   instrCode[30:21], 1'b0};

    always_comb begin
        case (instrCode[6:0])
            riscvPkg::OP_I: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    immExt = {27'd0, instrCode[24:20]}; // shift amount.
                end else begin
                    immExt = immI; // sltiu also sign-extends.
                end
            end
            riscvPkg::OP_L:     immExt = immI;
            riscvPkg::OP_JALR:  immExt = immI;
            riscvPkg::OP_S:     immExt = immS;
            riscvPkg::OP_B:     immExt = immB;
            riscvPkg::OP_LUI:   immExt = immU;
            riscvPkg::OP_AUIPC: immExt = immU;
            riscvPkg::OP_JAL:   immExt = immJ;
            default:            immExt = '0;
        endcase
    end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  logic [4:0]        rAddr1,
    input  logic [4:0]        rAddr2,
    input  logic [4:0]        wAddr,
    input  riscvPkg::dataWord wData,
    output riscvPkg::dataWord rData1,
    output riscvPkg::dataWord rData2
);
    riscvPkg::dataWord regs [32];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != 5'd0) begin
            regs[wAddr] <= wData;
        end
    end

    // x0 is hardwired zero.
    assign rData1 = (rAddr1 != 5'd0) ? regs[rAddr1] : '0;
    assign rData2 = (rAddr2 != 5'd0) ? regs[rAddr2] : '0;

endmodule

// File: hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  riscvPkg::dataWord instrCode,
    output logic              regWe,
    output riscvPkg::aluOpT   aluOp,
    output logic              aluSrcImm,
    output logic              aluAPc,
    output riscvPkg::wbSelT   wbSel,
    output logic              branch,
    output logic              jump,
    output logic              jumpReg,
    output logic              memWe,
    output riscvPkg::accessT  access
);
    riscvPkg::opcodeT opcode;
    logic [2:0]       funct3;
    logic             funct7b5;
    riscvPkg::aluOpT  arithOp;

    assign opcode   = riscvPkg::opcodeT'(instrCode[6:0]);
    assign funct3   = instrCode[14:12];
    assign funct7b5 = instrCode[30];

    // arithmetic op from funct3, bit 30 splits add/sub and srl/sra.
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (opcode == riscvPkg::OP_R && funct7b5) ?
                               riscvPkg::ALU_SUB : riscvPkg::ALU_ADD;
            3'b001:  arithOp = riscvPkg::ALU_SLL;
            3'b010:  arithOp = riscvPkg::ALU_SLT;
            3'b011:  arithOp = riscvPkg::ALU_SLTU;
            3'b100:  arithOp = riscvPkg::ALU_XOR;
            3'b101:  arithOp = funct7b5 ? riscvPkg::ALU_SRA : riscvPkg::ALU_SRL;
            3'b110:  arithOp = riscvPkg::ALU_OR;
            default: arithOp = riscvPkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  access = riscvPkg::ACC_BYTE;
            3'b001:  access = riscvPkg::ACC_HALF;
            3'b100:  access = riscvPkg::ACC_UBYTE;
            3'b101:  access = riscvPkg::ACC_UHALF;
            default: access = riscvPkg::ACC_WORD;
        endcase
    end

    always_comb begin
        regWe     = 1'b0; // unknown opcode is a plain pc+4.
        aluOp     = riscvPkg::ALU_ADD;
        aluSrcImm = 1'b0;
        aluAPc    = 1'b0;
        wbSel     = riscvPkg::WB_ALU;
        branch    = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        memWe     = 1'b0;
        case (opcode)
            riscvPkg::OP_R: begin
                regWe = 1'b1;
                aluOp = arithOp;
            end
            riscvPkg::OP_I: begin
                regWe     = 1'b1;
                aluOp     = arithOp;
                aluSrcImm = 1'b1;
            end
            riscvPkg::OP_L: begin
                regWe     = 1'b1;
                aluSrcImm = 1'b1;
                wbSel     = riscvPkg::WB_MEM;
            end
            riscvPkg::OP_S: begin
                memWe     = 1'b1;
                aluSrcImm = 1'b1;
            end
            riscvPkg::OP_B: begin
                branch = 1'b1;
                case (funct3)
                    3'b000:  aluOp = riscvPkg::ALU_EQ;
                    3'b001:  aluOp = riscvPkg::ALU_NE;
                    3'b100:  aluOp = riscvPkg::ALU_LT;
                    3'b101:  aluOp = riscvPkg::ALU_GE;
                    3'b110:  aluOp = riscvPkg::ALU_LTU;
                    3'b111:  aluOp = riscvPkg::ALU_GEU;
                    default: branch = 1'b0; // reserved funct3.
                endcase
            end
            riscvPkg::OP_LUI: begin
                regWe = 1'b1;
                wbSel = riscvPkg::WB_IMM;
            end
            riscvPkg::OP_AUIPC: begin
                regWe     = 1'b1;
                aluSrcImm = 1'b1;
                aluAPc    = 1'b1;
            end
            riscvPkg::OP_JAL: begin
                regWe = 1'b1;
                wbSel = riscvPkg::WB_PCPLUS4;
                jump  = 1'b1;
            end
            riscvPkg::OP_JALR: begin
                regWe     = 1'b1;
                wbSel     = riscvPkg::WB_PCPLUS4;
                jumpReg   = 1'b1;
                aluSrcImm = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  riscvPkg::accessT  access,
    input  riscvPkg::dataWord addr,
    input  riscvPkg::dataWord wData,
    output riscvPkg::dataWord rData
);
    localparam int AW = $clog2(DMEM_WORDS);

    riscvPkg::dataWord mem [DMEM_WORDS];
    logic [AW-1:0]     wordIdx;
    riscvPkg::dataWord word;
    logic [7:0]        byteVal;
    logic [15:0]       halfVal;

    assign wordIdx = addr[AW+1:2]; // upper bits wrap.

    // ############################################################
    // stores, byte lanes picked by width and addr[1:0].
    // ############################################################
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            case (access)
                riscvPkg::ACC_BYTE, riscvPkg::ACC_UBYTE:
                    mem[wordIdx][8*addr[1:0] +: 8] <= wData[7:0];
                riscvPkg::ACC_HALF, riscvPkg::ACC_UHALF:
                    mem[wordIdx][16*addr[1] +: 16] <= wData[15:0];
                default:
                    mem[wordIdx] <= wData;
            endcase
        end
    end

    // loads are combinational.
    assign word    = mem[wordIdx];
    assign byteVal = word[8*addr[1:0] +: 8];
    assign halfVal = word[16*addr[1] +: 16];

    always_comb begin
        case (access)
            riscvPkg::ACC_BYTE:  rData = {{24{byteVal[7]}}, byteVal};
            riscvPkg::ACC_UBYTE: rData = {24'd0, byteVal};
            riscvPkg::ACC_HALF:  rData = {{16{halfVal[15]}}, halfVal};
            riscvPkg::ACC_UHALF: rData = {16'd0, halfVal};
            default:             rData = word;
        endcase
    end

endmodule

// File: hdl/dataPath.sv
`timescale 1ns/1ps

module dataPath #(
    parameter riscvPkg::dataWord RESET_PC = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  riscvPkg::dataWord instrCode,
    input  logic              regWe,
    input  riscvPkg::aluOpT   aluOp,
    input  logic              aluSrcImm,
    input  logic              aluAPc,
    input  riscvPkg::wbSelT   wbSel,
    input  logic              branch,
    input  logic              jump,
    input  logic              jumpReg,
    input  riscvPkg::dataWord loadData,
    output riscvPkg::dataWord instrAddr,
    output riscvPkg::dataWord dataAddr,
    output riscvPkg::dataWord storeData,
    output logic [4:0]        rfWAddr,
    output riscvPkg::dataWord rfWData
);
    riscvPkg::dataWord pc, nextPc;
    riscvPkg::dataWord pcPlus4, pcPlusImm, jumpTarget;
    riscvPkg::dataWord rData1, rData2;
    riscvPkg::dataWord immExt;
    riscvPkg::dataWord aluA, aluB, aluResult;
    logic              taken;

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign storeData = rData2;
    assign rfWAddr   = instrCode[11:7];

    // ############################################################
    // program counter.
    // ############################################################
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    assign pcPlus4    = pc + 32'd4;
    assign pcPlusImm  = pc + immExt;
    assign jumpTarget = {aluResult[31:1], 1'b0}; // jalr drops bit 0.
    assign taken      = branch & aluResult[0];

    always_comb begin
        if (jumpReg) begin
            nextPc = jumpTarget;
        end else if (jump || taken) begin
            nextPc = pcPlusImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // ############################################################
    // operands and write-back.
    // ############################################################
    assign aluA = aluAPc ? pc : rData1;
    assign aluB = aluSrcImm ? immExt : rData2;

    always_comb begin
        case (wbSel)
            riscvPkg::WB_MEM:     rfWData = loadData;
            riscvPkg::WB_IMM:     rfWData = immExt;
            riscvPkg::WB_PCPLUS4: rfWData = pcPlus4; // link value.
            default:              rfWData = aluResult;
        endcase
    end

    registerFile i_registerFile (
        .clk   (clk),
        .reset (reset),
        .we    (regWe),
        .rAddr1(instrCode[19:15]),
        .rAddr2(instrCode[24:20]),
        .wAddr (instrCode[11:7]),
        .wData (rfWData),
        .rData1(rData1),
        .rData2(rData2)
    );

    alu i_alu (
        .aluOp (aluOp),
        .a     (aluA),
        .b     (aluB),
        .result(aluResult)
    );

    immExtend i_immExtend (
        .instrCode(instrCode),
        .immExt   (immExt)
    );

endmodule

// File: hdl/riscvCore.sv
`timescale 1ns/1ps

module riscvCore #(
    parameter int                DMEM_WORDS = 256,
    parameter riscvPkg::dataWord RESET_PC   = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  riscvPkg::dataWord instrCode,
    output riscvPkg::dataWord instrAddr,
    output logic              rfWe,
    output logic [4:0]        rfWAddr,
    output riscvPkg::dataWord rfWData,
    output logic              storeWe,
    output riscvPkg::dataWord storeAddr,
    output riscvPkg::dataWord storeData
);
    logic              regWe, memWe;
    riscvPkg::aluOpT   aluOp;
    logic              aluSrcImm, aluAPc;
    riscvPkg::wbSelT   wbSel;
    logic              branch, jump, jumpReg;
    riscvPkg::accessT  access;
    riscvPkg::dataWord loadData;

    // no state change while reset is held.
    assign rfWe    = regWe & ~reset & (rfWAddr != 5'd0); // x0 is never reported.
    assign storeWe = memWe & ~reset;

    controlUnit i_controlUnit (
        .instrCode(instrCode),
        .regWe    (regWe),
        .aluOp    (aluOp),
        .aluSrcImm(aluSrcImm),
        .aluAPc   (aluAPc),
        .wbSel    (wbSel),
        .branch   (branch),
        .jump     (jump),
        .jumpReg  (jumpReg),
        .memWe    (memWe),
        .access   (access)
    );

    dataPath #(
        .RESET_PC(RESET_PC)
    ) i_dataPath (
        .clk      (clk),
        .reset    (reset),
        .instrCode(instrCode),
        .regWe    (rfWe),
        .aluOp    (aluOp),
        .aluSrcImm(aluSrcImm),
        .aluAPc   (aluAPc),
        .wbSel    (wbSel),
        .branch   (branch),
        .jump     (jump),
        .jumpReg  (jumpReg),
        .loadData (loadData),
        .instrAddr(instrAddr),
        .dataAddr (storeAddr),
        .storeData(storeData),
        .rfWAddr  (rfWAddr),
        .rfWData  (rfWData)
    );

    dataMemory #(
        .DMEM_WORDS(DMEM_WORDS)
    ) i_dataMemory (
        .clk   (clk),
        .reset (reset),
        .we    (storeWe),
        .access(access),
        .addr  (storeAddr),
        .wData (storeData),
        .rData (loadData)
    );

endmodule

// File: test/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int MEM_BYTES = DMEM_WORDS * 4;

// ############################################################
// architectural state, byte addressed like the ISA.
// ############################################################
riscvPkg::dataWord modelRegs [32];
logic [7:0]        modelMem [MEM_BYTES];
riscvPkg::dataWord modelPc;

// expected trace of the instruction being retired.
logic              expWe;
logic [4:0]        expRd;
riscvPkg::dataWord expWData;
logic              expStore;
riscvPkg::dataWord expStoreAddr;
riscvPkg::dataWord expStoreData;

function automatic void modelReset();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    for (int i = 0; i < MEM_BYTES; i++) begin
        modelMem[i] = 8'd0;
    end
    modelPc = RESET_PC;
endfunction

function automatic riscvPkg::dataWord arithResult(input logic [2:0] f3, input logic alt,
                                                  input riscvPkg::dataWord a,
                                                  input riscvPkg::dataWord b);
    case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return {31'd0, $signed(a) < $signed(b)};
        3'b011: return {31'd0, a < b};
        3'b100: return a ^ b;
        3'b101: begin
            if (alt) begin
                return $signed(a) >>> b[4:0]; // arithmetic shift.
            end
            return a >> b[4:0];
        end
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input riscvPkg::dataWord a,
                                     input riscvPkg::dataWord b);
    case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        3'b101: return $signed(a) >= $signed(b);
        3'b110: return a < b;
        3'b111: return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic riscvPkg::dataWord loadValue(input riscvPkg::dataWord addr,
                                                input logic [2:0] f3);
    int          i;
    logic [31:0] w;
    i = int'(addr % MEM_BYTES);
    w = {modelMem[(i + 3) % MEM_BYTES], modelMem[(i + 2) % MEM_BYTES],
         modelMem[(i + 1) % MEM_BYTES], modelMem[i]}; // little endian.
    case (f3)
        3'b000: return {{24{w[7]}}, w[7:0]};
        3'b001: return {{16{w[15]}}, w[15:0]};
        3'b100: return {24'd0, w[7:0]};
        3'b101: return {16'd0, w[15:0]};
        default: return w;
    endcase
endfunction

function automatic void storeBytes(input riscvPkg::dataWord addr, input logic [2:0] f3,
                                   input riscvPkg::dataWord data);
    int i;
    i = int'(addr % MEM_BYTES);
    for (int j = 0; j < (1 << f3[1:0]); j++) begin
        modelMem[(i + j) % MEM_BYTES] = data[8*j +: 8];
    end
endfunction

// ############################################################
// one instruction, sets the expected trace.
// ############################################################
function automatic void modelStep(input riscvPkg::dataWord ins);
    logic [4:0]        rd;
    logic [2:0]        f3;
    riscvPkg::dataWord a, b, immI, immS, immB, immU, immJ, nextPc;
    rd   = ins[11:7];
    f3   = ins[14:12];
    a    = modelRegs[ins[19:15]];
    b    = modelRegs[ins[24:20]];
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immU = {ins[31:12], 12'd0};
    immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    expWe        = 1'b0;
    expRd        = rd;
    expWData     = '0;
    expStore     = 1'b0;
    expStoreAddr = a + immS;
    expStoreData = b; // whole rs2 shows on the port.
    nextPc       = modelPc + 32'd4;
    case (ins[6:0])
        riscvPkg::OP_R: begin
            expWe    = 1'b1;
            expWData = arithResult(f3, ins[30], a, b);
        end
        riscvPkg::OP_I: begin
            expWe    = 1'b1;
            expWData = arithResult(f3, ins[30] && f3 == 3'b101, a, immI);
        end
        riscvPkg::OP_L: begin
            expWe    = 1'b1;
            expWData = loadValue(a + immI, f3);
        end
        riscvPkg::OP_S: begin
            expStore = 1'b1;
            storeBytes(expStoreAddr, f3, b);
        end
        riscvPkg::OP_B: begin
            if (branchTaken(f3, a, b)) begin
                nextPc = modelPc + immB;
            end
        end
        riscvPkg::OP_LUI: begin
            expWe    = 1'b1;
            expWData = immU;
        end
        riscvPkg::OP_AUIPC: begin
            expWe    = 1'b1;
            expWData = modelPc + immU;
        end
        riscvPkg::OP_JAL: begin
            expWe    = 1'b1;
            expWData = modelPc + 32'd4;
            nextPc   = modelPc + immJ;
        end
        riscvPkg::OP_JALR: begin
            expWe    = 1'b1;
            expWData = modelPc + 32'd4;
            nextPc   = (a + immI) & ~32'd1;
        end
        default: ;
    endcase
    if (rd == 5'd0) begin
        expWe = 1'b0; // x0 is never written.
    end
    if (expWe) begin
        modelRegs[rd] = expWData;
    end
    modelPc = nextPc;
endfunction

`endif

// File: test/tb.sv
`timescale 1ns/1ps

module tb;

    localparam int                DMEM_WORDS = 256;
    localparam riscvPkg::dataWord RESET_PC   = 32'h0000_0000;
    localparam int                PROG_WORDS = 512;
    localparam int                PROG_AW    = $clog2(PROG_WORDS);
    localparam int                RUN_CYCLES = 3000;

    logic              clk = 1'b0;
    logic              reset;
    riscvPkg::dataWord instrCode;
    riscvPkg::dataWord instrAddr;
    logic              rfWe;
    logic [4:0]        rfWAddr;
    riscvPkg::dataWord rfWData;
    logic              storeWe;
    riscvPkg::dataWord storeAddr;
    riscvPkg::dataWord storeData;

    riscvPkg::dataWord progMem [PROG_WORDS];
    riscvPkg::dataWord fetchOffset;
    logic [31:0]       lcgState = 32'hae5f_e50b;
    logic [2:0]        loadWidths [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

    `include "isaModel.svh"

    riscvCore #(
        .DMEM_WORDS(DMEM_WORDS),
        .RESET_PC  (RESET_PC)
    ) i_riscvCore (
        .clk      (clk),
        .reset    (reset),
        .instrCode(instrCode),
        .instrAddr(instrAddr),
        .rfWe     (rfWe),
        .rfWAddr  (rfWAddr),
        .rfWData  (rfWData),
        .storeWe  (storeWe),
        .storeAddr(storeAddr),
        .storeData(storeData)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // instruction memory answers in the same cycle.
    always_comb begin
        fetchOffset = instrAddr - RESET_PC;
        if (fetchOffset < PROG_WORDS * 4) begin
            instrCode = progMem[fetchOffset[PROG_AW+1:2]];
        end else begin
            instrCode = '0;
        end
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // ############################################################
    // program generation, targets stay inside the program.
    // ############################################################
    function automatic riscvPkg::dataWord makeInstr(input int k);
        logic [31:0] r1, r2, off;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic        alt;
        int          target;
        r1     = lcgNext();
        r2     = lcgNext();
        rd     = {1'b0, r1[27:24]}; // x0..x15 for more reuse.
        rs1    = {1'b0, r1[23:20]};
        rs2    = {1'b0, r1[19:16]};
        f3     = r1[15:13];
        alt    = r1[12];
        imm    = r2[31:20];
        target = int'(r2[30:22]);
        if (target == k) begin
            target = (k + 1) % PROG_WORDS; // no self loops.
        end
        off = (target - k) * 4;
        if (k == PROG_WORDS - 1) begin
            // last word jumps back, pc never runs off the end.
            return {off[20], off[10:1], off[11], off[19:12], rd, riscvPkg::OP_JAL};
        end
        case (r1[31:28])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'd0;
                return {f7, rs2, rs1, f3, rd, riscvPkg::OP_R};
            end
            4'd4, 4'd5, 4'd6: begin
                if (f3 == 3'b001) begin
                    imm = {7'd0, r2[24:20]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, alt, 5'd0, r2[24:20]};
                end
                return {imm, rs1, f3, rd, riscvPkg::OP_I};
            end
            4'd7: return {r2[31:12], rd, riscvPkg::OP_LUI};
            4'd8: return {r2[31:12], rd, riscvPkg::OP_AUIPC};
            4'd9, 4'd10: begin
                f3  = loadWidths[int'(r2[19:17]) % 5];
                off = {22'd0, r2[31:22]} % MEM_BYTES;
                off = off & ~((32'd1 << f3[1:0]) - 32'd1);
                return {off[11:0], 5'd0, f3, rd, riscvPkg::OP_L};
            end
            4'd11, 4'd12: begin
                f3  = (r2[18:17] == 2'b11) ? 3'b010 : {1'b0, r2[18:17]};
                off = {22'd0, r2[31:22]} % MEM_BYTES;
                off = off & ~((32'd1 << f3[1:0]) - 32'd1);
                return {off[11:5], rs2, 5'd0, f3, off[4:0], riscvPkg::OP_S};
            end
            4'd13, 4'd14: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscvPkg::OP_B};
            end
            default: begin
                if (alt) begin
                    return {off[20], off[10:1], off[11], off[19:12], rd, riscvPkg::OP_JAL};
                end
                off = RESET_PC + target * 4 + int'(r2[21]); // odd target, bit 0 dropped.
                return {off[11:0], 5'd0, 3'b000, rd, riscvPkg::OP_JALR};
            end
        endcase
    endfunction

    task automatic stopWithError(input string text);
        $display("%s", text);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic comparePc(input riscvPkg::dataWord got, input riscvPkg::dataWord exp);
        if (got !== exp) begin
            stopWithError($sformatf("FAIL %0t: instrAddr %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic compareRegWrite(input logic gotWe, input logic [4:0] gotAddr,
                                   input riscvPkg::dataWord gotData, input logic wantWe,
                                   input logic [4:0] wantAddr,
                                   input riscvPkg::dataWord wantData);
        if (gotWe !== wantWe) begin
            stopWithError($sformatf("FAIL %0t: rfWe %b, expected %b at pc %h",
                                    $time, gotWe, wantWe, instrAddr));
        end else if (wantWe && (gotAddr !== wantAddr || gotData !== wantData)) begin
            stopWithError($sformatf("FAIL %0t: write x%0d = %h, expected x%0d = %h at pc %h",
                                    $time, gotAddr, gotData, wantAddr, wantData, instrAddr));
        end
    endtask

    task automatic compareStore(input logic gotWe, input riscvPkg::dataWord gotAddr,
                                input riscvPkg::dataWord gotData, input logic wantWe,
                                input riscvPkg::dataWord wantAddr,
                                input riscvPkg::dataWord wantData);
        if (gotWe !== wantWe) begin
            stopWithError($sformatf("FAIL %0t: storeWe %b, expected %b at pc %h",
                                    $time, gotWe, wantWe, instrAddr));
        end else if (wantWe && (gotAddr !== wantAddr || gotData !== wantData)) begin
            stopWithError($sformatf("FAIL %0t: store [%h] = %h, expected [%h] = %h",
                                    $time, gotAddr, gotData, wantAddr, wantData));
        end
    endtask

    task automatic checkResetState();
        comparePc(instrAddr, RESET_PC);
        compareRegWrite(rfWe, rfWAddr, rfWData, 1'b0, 5'd0, '0);
        compareStore(storeWe, storeAddr, storeData, 1'b0, '0, '0);
    endtask

    // called mid-cycle, before the edge that retires the instruction.
    task automatic checkCycle();
        if (fetchOffset >= PROG_WORDS * 4 || instrAddr[1:0] != 2'b00) begin
            stopWithError($sformatf("instruction fetch at %h is outside the program",
                                    instrAddr));
        end
        comparePc(instrAddr, modelPc);
        modelStep(instrCode);
        compareRegWrite(rfWe, rfWAddr, rfWData, expWe, expRd, expWData);
        compareStore(storeWe, storeAddr, storeData, expStore, expStoreAddr, expStoreData);
    endtask

    initial begin
        reset <= 1'b1;
        for (int k = 0; k < PROG_WORDS; k++) begin
            progMem[k] = makeInstr(k);
        end
        modelReset();
        repeat (2) begin
            @(negedge clk);
            checkResetState();
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            checkCycle();
            @(negedge clk);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+test
hdl/riscvPkg.sv
hdl/alu.sv
hdl/immExtend.sv
hdl/registerFile.sv
hdl/controlUnit.sv
hdl/dataMemory.sv
hdl/dataPath.sv
hdl/riscvCore.sv
test/tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb -f tb.f --Mdir obj_dir -o simv
./obj_dir/simv | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
